// File: tb/ras_stimulus.txt
// First value is the step count, then one step per line with the columns
// fetch_instr commit_valid commit_pc commit_instr recover recover_pc expected_fetch_pc
00000033
// Sequential words and a J
00000000 0 00000000 00000000 0 00000000 bfc00004
00000000 0 00000000 00000000 0 00000000 bfc00008
0bf00040 0 00000000 00000000 0 00000000 bfc00100
00000000 0 00000000 00000000 0 00000000 bfc00104
// Three nested calls and their returns
0ff00080 0 00000000 00000000 0 00000000 bfc00200
00000000 0 00000000 00000000 0 00000000 bfc00204
0ff000c0 0 00000000 00000000 0 00000000 bfc00300
0ff00100 0 00000000 00000000 0 00000000 bfc00400
03e00008 0 00000000 00000000 0 00000000 bfc00308
03e00008 0 00000000 00000000 0 00000000 bfc0020c
03e00008 0 00000000 00000000 0 00000000 bfc0010c
00000000 0 00000000 00000000 0 00000000 bfc00110
// Wrong-path calls, a different call retires, then recover with a same-cycle commit
0ff00140 1 bfc00800 0ff00240 0 00000000 bfc00500
0ff00180 0 00000000 00000000 0 00000000 bfc00600
00000000 1 bfc00a00 0ff002c0 1 bfc00700 bfc00700
03e00008 0 00000000 00000000 0 00000000 bfc00808
00000000 0 00000000 00000000 0 00000000 bfc0080c
// Seventeen nested calls, one more than the stack holds
0ff00400 0 00000000 00000000 0 00000000 bfc01000
0ff00404 0 00000000 00000000 0 00000000 bfc01010
0ff00408 0 00000000 00000000 0 00000000 bfc01020
0ff0040c 0 00000000 00000000 0 00000000 bfc01030
0ff00410 0 00000000 00000000 0 00000000 bfc01040
0ff00414 0 00000000 00000000 0 00000000 bfc01050
0ff00418 0 00000000 00000000 0 00000000 bfc01060
0ff0041c 0 00000000 00000000 0 00000000 bfc01070
0ff00420 0 00000000 00000000 0 00000000 bfc01080
0ff00424 0 00000000 00000000 0 00000000 bfc01090
0ff00428 0 00000000 00000000 0 00000000 bfc010a0
0ff0042c 0 00000000 00000000 0 00000000 bfc010b0
0ff00430 0 00000000 00000000 0 00000000 bfc010c0
0ff00434 0 00000000 00000000 0 00000000 bfc010d0
0ff00438 0 00000000 00000000 0 00000000 bfc010e0
0ff0043c 0 00000000 00000000 0 00000000 bfc010f0
0ff00440 0 00000000 00000000 0 00000000 bfc01100
// Returns, the last one finds the newest link again
03e00008 0 00000000 00000000 0 00000000 bfc010f8
03e00008 0 00000000 00000000 0 00000000 bfc010e8
03e00008 0 00000000 00000000 0 00000000 bfc010d8
03e00008 0 00000000 00000000 0 00000000 bfc010c8
03e00008 0 00000000 00000000 0 00000000 bfc010b8
03e00008 0 00000000 00000000 0 00000000 bfc010a8
03e00008 0 00000000 00000000 0 00000000 bfc01098
03e00008 0 00000000 00000000 0 00000000 bfc01088
03e00008 0 00000000 00000000 0 00000000 bfc01078
03e00008 0 00000000 00000000 0 00000000 bfc01068
03e00008 0 00000000 00000000 0 00000000 bfc01058
03e00008 0 00000000 00000000 0 00000000 bfc01048
03e00008 0 00000000 00000000 0 00000000 bfc01038
03e00008 0 00000000 00000000 0 00000000 bfc01028
03e00008 0 00000000 00000000 0 00000000 bfc01018
03e00008 0 00000000 00000000 0 00000000 bfc01008
03e00008 0 00000000 00000000 0 00000000 bfc010f8

// File: tb.f
source/ras_pkg.sv
source/mips_predecode.sv
source/return_stack.sv
source/fetch_pc_gen.sv
source/ras_predictor_top.sv
tb/ras_predictor_assert.sv
tb/tb_ras_predictor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ras_predictor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The result is decided by the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_ras_predictor.sv
`timescale 1ns/1ps

module tb_ras_predictor
    import ras_pkg::*;
();

    localparam int ras_depth     = 16;
    localparam int clk_half      = 20;
    localparam int drive_delay   = 2;
    localparam int reset_cycles  = 5;
    localparam int reset_timeout = 20;

    // Words per step in the stimulus file
    localparam int fields    = 7;
    localparam int max_steps = 64;

    // JR $ra, the only encoding that counts as a return
    localparam instr_t jr_ra = 32'h03e0_0008;

    // Pause generator, x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam logic [31:0] lfsr_seed = 32'd90008;

    logic   clk;
    logic   rst;
    logic   fetch_valid;
    instr_t fetch_instr;
    logic   pause;
    logic   recover;
    addr_t  recover_pc;
    logic   commit_valid;
    addr_t  commit_pc;
    instr_t commit_instr;
    addr_t  fetch_pc;
    addr_t  pred_target;

    // Entry 0 is the step count, then seven words per step
    logic [31:0] stim_mem [0:fields*max_steps];

    logic [31:0] lfsr;
    int          num_steps;
    int          checks;
    int          errors;
    int          pauses;

    ras_predictor_top #(
        .ras_depth (ras_depth)
    ) ras_predictor_top_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .pause        (pause),
        .recover      (recover),
        .recover_pc   (recover_pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_instr (commit_instr),
        .fetch_pc     (fetch_pc),
        .pred_target  (pred_target)
    );

    // 40 ns period
    always #(clk_half) clk = ~clk;

    // One shift of the Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ lfsr_taps;
        end
        return shifted;
    endfunction

    // One bit per pause decision
    task automatic draw_bit(output logic bit_out);
        bit_out = lfsr[0];
        lfsr    = lfsr_next(lfsr);
    endtask

    task automatic idle_inputs();
        fetch_valid  = 1'b0;
        fetch_instr  = '0;
        pause        = 1'b0;
        recover      = 1'b0;
        recover_pc   = '0;
        commit_valid = 1'b0;
        commit_pc    = '0;
        commit_instr = '0;
    endtask

    task automatic check_addr(input string what, input addr_t expected, input addr_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    // Reset vector must show up within a bounded number of cycles
    task automatic wait_for_reset_pc();
        int waited;
        waited = 0;
        while (fetch_pc !== reset_pc && waited < reset_timeout) begin
            @(posedge clk);
            #(drive_delay);
            waited++;
        end
        if (fetch_pc !== reset_pc) begin
            $display("Timeout: fetch address never reached the reset vector in %0d cycles",
                     waited);
            errors++;
        end
    endtask

    // Stall cycle, no word offered, nothing may move
    task automatic run_pause_cycle();
        addr_t pc_before;
        addr_t target_before;
        idle_inputs();
        pause         = 1'b1;
        pc_before     = fetch_pc;
        target_before = pred_target;
        @(posedge clk);
        #(drive_delay);
        check_addr("fetch_pc after pause", pc_before, fetch_pc);
        check_addr("pred_target after pause", target_before, pred_target);
        pauses++;
    endtask

    // Offer one word with its commit and recover fields
    task automatic run_step(input int idx);
        int    base;
        addr_t expected;
        base         = 1 + fields * idx;
        fetch_valid  = 1'b1;
        pause        = 1'b0;
        fetch_instr  = stim_mem[base];
        commit_valid = stim_mem[base + 1][0];
        commit_pc    = stim_mem[base + 2];
        commit_instr = stim_mem[base + 3];
        recover      = stim_mem[base + 4][0];
        recover_pc   = stim_mem[base + 5];
        expected     = stim_mem[base + 6];
        // Pending link is visible before the return is taken
        if (fetch_instr == jr_ra && !recover) begin
            check_addr($sformatf("pred_target at step %0d", idx), expected, pred_target);
        end
        @(posedge clk);
        #(drive_delay);
        check_addr($sformatf("fetch_pc at step %0d", idx), expected, fetch_pc);
    endtask

    initial begin
        int   step;
        logic take_pause;
        clk    = 1'b0;
        rst    = 1'b1;
        idle_inputs();
        lfsr   = lfsr_seed;
        checks = 0;
        errors = 0;
        pauses = 0;
        $readmemh("tb/ras_stimulus.txt", stim_mem);
        num_steps = stim_mem[0];
        if (num_steps < 1 || num_steps > max_steps) begin
            $display("Stimulus file holds an invalid step count of %0d", num_steps);
            errors++;
            num_steps = 0;
        end

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        wait_for_reset_pc();
        check_addr("fetch_pc after reset", reset_pc, fetch_pc);
        check_addr("pred_target after reset", '0, pred_target);

        for (step = 0; step < num_steps; step++) begin
            draw_bit(take_pause);
            if (take_pause) begin
                run_pause_cycle();
            end
            run_step(step);
        end

        // Let the bound checks see the last step settle
        idle_inputs();
        @(posedge clk);
        #(drive_delay);

        $display("Steps: %0d, pause cycles: %0d, checks: %0d, errors: %0d",
                 num_steps, pauses, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb/ras_predictor_assert.sv
`timescale 1ns/1ps

module ras_predictor_assert
    import ras_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  pause,
    input logic  recover,
    input addr_t recover_pc,
    input addr_t fetch_pc
);

    // Fetch only ever moves between whole words
    fetch_aligned: assert property (
        @(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00
    ) else $error("fetch_pc %h is not word aligned", fetch_pc);

    // Stall without redirect freezes the fetch address
    pause_holds_pc: assert property (
        @(posedge clk) disable iff (rst)
        pause && !recover |=> $stable(fetch_pc)
    ) else $error("fetch_pc changed after a pause cycle");

    // Redirect lands exactly one cycle later
    recover_loads_pc: assert property (
        @(posedge clk) disable iff (rst)
        recover |=> fetch_pc == $past(recover_pc)
    ) else $error("fetch_pc %h did not take the recover address", fetch_pc);

endmodule

bind fetch_pc_gen ras_predictor_assert fetch_pc_gen_assert_i (
    .clk        (clk),
    .rst        (rst),
    .pause      (pause),
    .recover    (recover),
    .recover_pc (recover_pc),
    .fetch_pc   (fetch_pc)
);

// File: source/ras_predictor_top.sv
`timescale 1ns/1ps

module ras_predictor_top
    import ras_pkg::*;
#(
    parameter int ras_depth = 16
) (
    input  logic   clk,
    input  logic   rst,

    // Fetch side
    input  logic   fetch_valid,
    input  instr_t fetch_instr,
    input  logic   pause,

    // Redirect
    input  logic   recover,
    input  addr_t  recover_pc,

    // Retire stream
    input  logic   commit_valid,
    input  addr_t  commit_pc,
    input  instr_t commit_instr,

    output addr_t  fetch_pc,
    output addr_t  pred_target
);

    // Fetch predecode results
    inst_kind_e fetch_kind;
    addr_t      fetch_target;
    addr_t      fetch_link;

    // Commit predecode results, the direct target is not needed there
    inst_kind_e commit_kind;
    addr_t      commit_link;

    // Stack update strobes
    logic spec_push;
    logic spec_pop;
    logic commit_push;
    logic commit_pop;

    // Fetch word classification
    mips_predecode fetch_dec_i (
        .pc            (fetch_pc),
        .instr         (fetch_instr),
        .kind          (fetch_kind),
        .direct_target (fetch_target),
        .link_addr     (fetch_link)
    );

    // Retired word classification
    mips_predecode commit_dec_i (
        .pc            (commit_pc),
        .instr         (commit_instr),
        .kind          (commit_kind),
        .direct_target (),
        .link_addr     (commit_link)
    );

    // Stall blocks speculative updates, recover priority is resolved in the stack
    assign spec_push = fetch_valid && !pause && (fetch_kind == kind_call);
    assign spec_pop  = fetch_valid && !pause && (fetch_kind == kind_return);

    // Retirement ignores stall and recover
    assign commit_push = commit_valid && (commit_kind == kind_call);
    assign commit_pop  = commit_valid && (commit_kind == kind_return);

    return_stack #(
        .ras_depth (ras_depth)
    ) return_stack_i (
        .clk         (clk),
        .rst         (rst),
        .spec_push   (spec_push),
        .spec_pop    (spec_pop),
        .spec_link   (fetch_link),
        .recover     (recover),
        .commit_push (commit_push),
        .commit_pop  (commit_pop),
        .commit_link (commit_link),
        .top_addr    (pred_target)
    );

    // Stack top feeds the return prediction directly
    fetch_pc_gen fetch_pc_gen_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .pause         (pause),
        .recover       (recover),
        .recover_pc    (recover_pc),
        .kind          (fetch_kind),
        .direct_target (fetch_target),
        .ras_top       (pred_target),
        .fetch_pc      (fetch_pc)
    );

endmodule

// File: source/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen
    import ras_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Word for the current fetch_pc is present
    input  logic       fetch_valid,
    input  logic       pause,

    // Redirect from the back end
    input  logic       recover,
    input  addr_t      recover_pc,

    // Predecode of the current word
    input  inst_kind_e kind,
    input  addr_t      direct_target,

    // Speculative stack top
    input  addr_t      ras_top,

    output addr_t      fetch_pc
);

    // Predicted address of the next fetch
    addr_t next_pc;

    // Advance only on a valid word while fetch is not stalled
    logic advance;

    always_comb begin
        unique case (kind)
            kind_return: next_pc = ras_top;
            kind_call,
            kind_jump:   next_pc = direct_target;
            default:     next_pc = fetch_pc + 32'd4;
        endcase
    end

    assign advance = fetch_valid && !pause;

    // Reset, then recover, then a normal advance
    // Anything else holds the current address
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= reset_pc;
        end else if (recover) begin
            fetch_pc <= recover_pc;
        end else if (advance) begin
            fetch_pc <= next_pc;
        end
    end

endmodule

// File: source/return_stack.sv
`timescale 1ns/1ps

module return_stack
    import ras_pkg::*;
#(
    // Must be a power of two so the pointer wraps by itself
    parameter int ras_depth = 16
) (
    input  logic  clk,
    input  logic  rst,

    // Speculative side, driven from fetch
    input  logic  spec_push,
    input  logic  spec_pop,
    input  addr_t spec_link,
    input  logic  recover,

    // Committed side, driven from retired instructions
    input  logic  commit_push,
    input  logic  commit_pop,
    input  addr_t commit_link,

    // Predicted return address
    output addr_t top_addr
);

    localparam int ptr_w = $clog2(ras_depth);

    // Speculative copy, used for prediction
    addr_t            spec_ras [ras_depth];
    logic [ptr_w-1:0] spec_ptr;

    // Committed copy, only retired calls and returns touch it
    addr_t            commit_ras [ras_depth];
    logic [ptr_w-1:0] commit_ptr;

    // Pointer addresses the next free slot, top is one below
    logic [ptr_w-1:0] spec_top_idx;

    assign spec_top_idx = spec_ptr - 1'b1;

    // Wraps to the last entry when the pointer sits at zero
    assign top_addr = spec_ras[spec_top_idx];

    // Speculative stack
    // Recover wins over push, push wins over pop
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ras_depth; i++) begin
                spec_ras[i] <= '0;
            end
            spec_ptr <= '0;
        end else if (recover) begin
            // Old committed contents, a same-cycle commit is not seen here
            for (int i = 0; i < ras_depth; i++) begin
                spec_ras[i] <= commit_ras[i];
            end
            spec_ptr <= commit_ptr;
        end else if (spec_push) begin
            // Oldest entry is overwritten once the stack is full
            spec_ras[spec_ptr] <= spec_link;
            spec_ptr           <= spec_ptr + 1'b1;
        end else if (spec_pop) begin
            spec_ptr <= spec_ptr - 1'b1;
        end
    end

    // Committed stack
    // Keeps running through pause and recover
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ras_depth; i++) begin
                commit_ras[i] <= '0;
            end
            commit_ptr <= '0;
        end else if (commit_push) begin
            commit_ras[commit_ptr] <= commit_link;
            commit_ptr             <= commit_ptr + 1'b1;
        end else if (commit_pop) begin
            // Popped entry stays in place, only the pointer moves
            commit_ptr <= commit_ptr - 1'b1;
        end
    end

endmodule

// File: source/mips_predecode.sv
`timescale 1ns/1ps

module mips_predecode
    import ras_pkg::*;
(
    input  addr_t      pc,
    input  instr_t     instr,
    output inst_kind_e kind,
    output addr_t      direct_target,
    output addr_t      link_addr
);

    // Instruction fields
    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs;

    // Sequential address, its top nibble selects the jump region
    addr_t pc_plus4;

    // Decoded instruction classes
    logic is_call;
    logic is_jump;
    logic is_return;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign funct  = instr[5:0];

    assign pc_plus4 = pc + 32'd4;

    // JAL and J carry the same 26-bit index
    assign is_call = (opcode == opcode_jal);
    assign is_jump = (opcode == opcode_j);

    // Only JR $ra counts as a return
    // JR through any other register is treated as an ordinary instruction
    assign is_return = (opcode == opcode_special)
                    && (funct == funct_jr)
                    && (rs == ra_reg);

    always_comb begin
        // Default is the sequential path
        kind = kind_other;
        if (is_call) begin
            kind = kind_call;
        end else if (is_jump) begin
            kind = kind_jump;
        end else if (is_return) begin
            kind = kind_return;
        end
    end

    // Region of pc + 4, then the word index shifted to a byte address
    assign direct_target = {pc_plus4[31:28], instr[25:0], 2'b00};

    // Return lands after the delay slot
    assign link_addr = pc + link_offset;

endmodule

// File: source/ras_pkg.sv
package ras_pkg;

    // Byte address as seen by fetch and commit
    typedef logic [31:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Major opcode field, bits 31:26
    typedef logic [5:0] opcode_t;

    // Function field of SPECIAL instructions, bits 5:0
    typedef logic [5:0] funct_t;

    // Register index, used for the rs field
    typedef logic [4:0] reg_idx_t;

    // Instruction classes that matter to the predictor
    typedef enum logic [1:0] {
        kind_other  = 2'd0,
        kind_call   = 2'd1,
        kind_jump   = 2'd2,
        kind_return = 2'd3
    } inst_kind_e;

    // Boot vector of a MIPS-style core
    localparam addr_t reset_pc = 32'hbfc0_0000;

    // Call plus delay slot, so the return lands after the slot
    localparam addr_t link_offset = 32'd8;

    // Link register
    localparam reg_idx_t ra_reg = 5'd31;

    // Opcodes and function codes decoded by the predecoder
    localparam opcode_t opcode_special = 6'h00;
    localparam opcode_t opcode_j       = 6'h02;
    localparam opcode_t opcode_jal     = 6'h03;
    localparam funct_t  funct_jr       = 6'h08;

endpackage
